/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := clockOverlayTb
FILELIST  := files.f
OBJDIR    := obj_dir
PASSMSG   := Verification passed

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

# Result comes from the simulator output, exit status from grep
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

/* files.f */
source/clockOverlayPkg.sv
source/fieldLocator.sv
source/charSelector.sv
source/backgroundBands.sv
source/glyphAddressReg.sv
source/clockOverlay.sv
testbench/clockOverlay_assert.sv
testbench/clockOverlayTb.sv

/* source/backgroundBands.sv */
`timescale 1ns/1ps

module backgroundBands import clockOverlayPkg::*; #(
  parameter int ScreenLines = 480  // Last visible line
) (
  input  coordT pixelY,
  output colorT bandColor
);

  localparam coordT lastLine = coordT'(ScreenLines);

  // Horizontal bands, top to bottom
  always_comb begin
    if (pixelY <= 10'd140)
      bandColor = colorBackground;
    else if (pixelY <= 10'd348)
      bandColor = colorBand;  // Former panel area plus the strip under it
    else if (pixelY <= 10'd351)
      bandColor = colorBackground;  // Thin gap
    else if (pixelY <= 10'd353)
      bandColor = colorBand;
    else if (pixelY <= 10'd472)
      bandColor = colorBackground;
    else if (pixelY <= lastLine) begin
      // Footer bar in the text colour
      bandColor = colorText;
    end else
      bandColor = colorBackground;  // Blanking lines
  end

endmodule

/* source/charSelector.sv */
`timescale 1ns/1ps

module charSelector import clockOverlayPkg::*; (
  input  fieldT    field,
  input  charCodeT hourTens,
  input  charCodeT hourUnits,
  input  charCodeT minTens,
  input  charCodeT minUnits,
  input  charCodeT secTens,
  input  charCodeT secUnits,
  input  charCodeT dateTens,
  input  charCodeT dateUnits,
  input  charCodeT monthTens,
  input  charCodeT monthUnits,
  input  charCodeT yearTens,
  input  charCodeT yearUnits,
  input  charCodeT dayTens,
  input  charCodeT dayUnits,
  input  charCodeT weekTens,
  input  charCodeT weekUnits,
  output charCodeT textChar,
  output fontSizeT textFont,
  output colorT    textColor
);

  always_comb begin
    case (field)
      fieldSecTens:    textChar = secTens;
      fieldSecUnits:   textChar = secUnits;
      fieldMinTens:    textChar = minTens;
      fieldMinUnits:   textChar = minUnits;
      fieldHourTens:   textChar = hourTens;
      fieldHourUnits:  textChar = hourUnits;
      fieldLabelS:     textChar = 7'h53;  // S
      fieldLabelE:     textChar = 7'h45;  // E
      fieldLabelM:     textChar = 7'h4D;  // M
      fieldLabelA1:    textChar = 7'h41;  // A
      fieldLabelN:     textChar = 7'h4E;  // N
      fieldLabelA2:    textChar = 7'h41;
      fieldWeekUnits:  textChar = weekUnits;
      fieldWeekTens:   textChar = weekTens;
      fieldDayTens:    textChar = dayTens;
      fieldDayUnits:   textChar = dayUnits;
      fieldDateTens:   textChar = dateTens;
      fieldDateUnits:  textChar = dateUnits;
      fieldYearZero:   textChar = 7'h30;  // Second digit of the "20" prefix
      fieldYearTwo:    textChar = 7'h32;
      fieldYearTens:   textChar = yearTens;
      fieldYearUnits:  textChar = yearUnits;
      fieldMonthTens:  textChar = monthTens;
      fieldMonthUnits: textChar = monthUnits;
      default:         textChar = blankChar;
    endcase
  end

  // Only the year prefix zero is drawn scaled up
  assign textFont = (field == fieldYearZero) ? fontLarge : fontNormal;

  // All text shares one palette entry
  assign textColor = colorText;

endmodule

/* source/clockOverlay.sv */
`timescale 1ns/1ps

module clockOverlay import clockOverlayPkg::*; #(
  parameter int ScreenLines = 480
) (
  input  logic     clk,
  input  logic     rstN,
  input  coordT    pixelX,
  input  coordT    pixelY,
  input  charCodeT hourTens,
  input  charCodeT hourUnits,
  input  charCodeT minTens,
  input  charCodeT minUnits,
  input  charCodeT secTens,
  input  charCodeT secUnits,
  input  charCodeT dateTens,
  input  charCodeT dateUnits,
  input  charCodeT monthTens,
  input  charCodeT monthUnits,
  input  charCodeT yearTens,
  input  charCodeT yearUnits,
  input  charCodeT dayTens,
  input  charCodeT dayUnits,
  input  charCodeT weekTens,
  input  charCodeT weekUnits,
  output romAddrT  romAddr,
  output fontSizeT fontSize,
  output colorT    colorSel,
  output logic     glyphEnable
);

  fieldT    field;      // Rectangle hit for the current pixel
  charCodeT textChar;
  fontSizeT textFont;
  colorT    textColor;
  colorT    bandColor;

  fieldLocator uLocator (
    .pixelX (pixelX),
    .pixelY (pixelY),
    .field  (field)
  );

  charSelector uSelector (
    .field      (field),
    .hourTens   (hourTens),
    .hourUnits  (hourUnits),
    .minTens    (minTens),
    .minUnits   (minUnits),
    .secTens    (secTens),
    .secUnits   (secUnits),
    .dateTens   (dateTens),
    .dateUnits  (dateUnits),
    .monthTens  (monthTens),
    .monthUnits (monthUnits),
    .yearTens   (yearTens),
    .yearUnits  (yearUnits),
    .dayTens    (dayTens),
    .dayUnits   (dayUnits),
    .weekTens   (weekTens),
    .weekUnits  (weekUnits),
    .textChar   (textChar),
    .textFont   (textFont),
    .textColor  (textColor)
  );

  backgroundBands #(
    .ScreenLines (ScreenLines)
  ) uBands (
    .pixelY    (pixelY),
    .bandColor (bandColor)
  );

  // Single pipeline stage, one cycle from coordinate to ROM address
  glyphAddressReg uAddrReg (
    .clk         (clk),
    .rstN        (rstN),
    .pixelY      (pixelY),
    .field       (field),
    .textChar    (textChar),
    .textFont    (textFont),
    .textColor   (textColor),
    .bandColor   (bandColor),
    .romAddr     (romAddr),
    .fontSize    (fontSize),
    .colorSel    (colorSel),
    .glyphEnable (glyphEnable)
  );

endmodule

/* source/clockOverlayPkg.sv */
package clockOverlayPkg;

  typedef logic [9:0] coordT;     // Screen x or y
  typedef logic [6:0] charCodeT;  // ASCII-like font ROM character
  typedef logic [10:0] romAddrT;  // Character in [10:4], glyph row in [3:0]

  typedef enum logic [2:0] {
    colorBackground = 3'd0,
    colorBand       = 3'd1,
    colorText       = 3'd2
  } colorT;

  typedef enum logic [1:0] {
    fontNormal = 2'd1,  // Glyph row from y[3:0]
    fontLarge  = 2'd2   // Glyph row from y[5:2]
  } fontSizeT;

  // Text rectangles, highest priority first
  typedef enum logic [4:0] {
    fieldSecTens, fieldSecUnits,
    fieldMinTens, fieldMinUnits,
    fieldHourTens, fieldHourUnits,
    fieldLabelS, fieldLabelE, fieldLabelM, fieldLabelA1, fieldLabelN, fieldLabelA2,
    fieldWeekUnits, fieldWeekTens,
    fieldDayTens, fieldDayUnits,
    fieldDateTens, fieldDateUnits,
    fieldYearZero, fieldYearTwo,
    fieldYearTens, fieldYearUnits,
    fieldMonthTens, fieldMonthUnits,
    fieldNone
  } fieldT;

  localparam charCodeT blankChar = 7'h0A;  // Empty glyph

  // Time of day, centre of screen
  localparam coordT hourTensXLo  = 10'd295;
  localparam coordT hourTensXHi  = 10'd302;
  localparam coordT hourUnitsXLo = 10'd303;
  localparam coordT hourUnitsXHi = 10'd310;
  localparam coordT hourYLo      = 10'd240;
  localparam coordT hourYHi      = 10'd255;
  localparam coordT minTensXLo   = 10'd319;
  localparam coordT minTensXHi   = 10'd326;
  localparam coordT minUnitsXLo  = 10'd327;
  localparam coordT minUnitsXHi  = 10'd334;
  localparam coordT minYLo       = 10'd240;
  localparam coordT minYHi       = 10'd255;
  localparam coordT secTensXLo   = 10'd343;
  localparam coordT secTensXHi   = 10'd351;
  localparam coordT secUnitsXLo  = 10'd352;
  localparam coordT secUnitsXHi  = 10'd359;
  localparam coordT secYLo       = 10'd242;  // Seconds sit two lines lower
  localparam coordT secYHi       = 10'd257;

  // Week label and week number along the top
  localparam coordT labelSXLo    = 10'd287;
  localparam coordT labelSXHi    = 10'd294;
  localparam coordT labelEXLo    = 10'd295;
  localparam coordT labelEXHi    = 10'd302;
  localparam coordT labelMXLo    = 10'd303;
  localparam coordT labelMXHi    = 10'd310;
  localparam coordT labelA1XLo   = 10'd311;
  localparam coordT labelA1XHi   = 10'd319;
  localparam coordT labelNXLo    = 10'd320;
  localparam coordT labelNXHi    = 10'd327;
  localparam coordT labelA2XLo   = 10'd328;
  localparam coordT labelA2XHi   = 10'd334;
  localparam coordT weekTensXLo  = 10'd343;
  localparam coordT weekTensXHi  = 10'd350;
  localparam coordT weekUnitsXLo = 10'd351;
  localparam coordT weekUnitsXHi = 10'd358;
  localparam coordT weekYLo      = 10'd16;
  localparam coordT weekYHi      = 10'd29;

  // Calendar block, bottom right
  localparam coordT dayTensXLo    = 10'd575;
  localparam coordT dayTensXHi    = 10'd582;
  localparam coordT dayUnitsXLo   = 10'd583;
  localparam coordT dayUnitsXHi   = 10'd590;
  localparam coordT dayYLo        = 10'd450;
  localparam coordT dayYHi        = 10'd461;
  localparam coordT dateTensXLo   = 10'd591;
  localparam coordT dateTensXHi   = 10'd598;
  localparam coordT dateUnitsXLo  = 10'd599;
  localparam coordT dateUnitsXHi  = 10'd606;
  localparam coordT dateYLo       = 10'd434;
  localparam coordT dateYHi       = 10'd446;
  localparam coordT yearTwoXLo    = 10'd583;
  localparam coordT yearTwoXHi    = 10'd590;
  localparam coordT yearZeroXLo   = 10'd591;
  localparam coordT yearZeroXHi   = 10'd598;
  localparam coordT yearTensXLo   = 10'd599;
  localparam coordT yearTensXHi   = 10'd606;
  localparam coordT yearUnitsXLo  = 10'd607;
  localparam coordT yearUnitsXHi  = 10'd614;
  localparam coordT yearYLo       = 10'd418;
  localparam coordT yearYHi       = 10'd428;
  localparam coordT monthTensXLo  = 10'd607;
  localparam coordT monthTensXHi  = 10'd614;
  localparam coordT monthUnitsXLo = 10'd615;
  localparam coordT monthUnitsXHi = 10'd622;
  localparam coordT monthYLo      = 10'd450;
  localparam coordT monthYHi      = 10'd461;

endpackage

/* source/fieldLocator.sv */
`timescale 1ns/1ps

module fieldLocator import clockOverlayPkg::*; (
  input  coordT pixelX,
  input  coordT pixelY,
  output fieldT field
);

  // Inclusive bound check on one axis
  function automatic logic inRange(input coordT v, input coordT lo, input coordT hi);
    return (v >= lo) && (v <= hi);
  endfunction

  logic hourRow;
  logic minRow;
  logic secRow;
  logic weekRow;
  logic dayRow;
  logic dateRow;
  logic yearRow;
  logic monthRow;

  // Row matches per group, shared by all columns of that group
  assign hourRow  = inRange(pixelY, hourYLo, hourYHi);
  assign minRow   = inRange(pixelY, minYLo, minYHi);
  assign secRow   = inRange(pixelY, secYLo, secYHi);
  assign weekRow  = inRange(pixelY, weekYLo, weekYHi);
  assign dayRow   = inRange(pixelY, dayYLo, dayYHi);
  assign dateRow  = inRange(pixelY, dateYLo, dateYHi);
  assign yearRow  = inRange(pixelY, yearYLo, yearYHi);
  assign monthRow = inRange(pixelY, monthYLo, monthYHi);

  // First hit wins, in fieldT order
  always_comb begin
    if (secRow && inRange(pixelX, secTensXLo, secTensXHi))
      field = fieldSecTens;
    else if (secRow && inRange(pixelX, secUnitsXLo, secUnitsXHi))
      field = fieldSecUnits;
    else if (minRow && inRange(pixelX, minTensXLo, minTensXHi))
      field = fieldMinTens;
    else if (minRow && inRange(pixelX, minUnitsXLo, minUnitsXHi))
      field = fieldMinUnits;
    else if (hourRow && inRange(pixelX, hourTensXLo, hourTensXHi))
      field = fieldHourTens;
    else if (hourRow && inRange(pixelX, hourUnitsXLo, hourUnitsXHi))
      field = fieldHourUnits;
    // Week label letters
    else if (weekRow && inRange(pixelX, labelSXLo, labelSXHi))
      field = fieldLabelS;
    else if (weekRow && inRange(pixelX, labelEXLo, labelEXHi))
      field = fieldLabelE;
    else if (weekRow && inRange(pixelX, labelMXLo, labelMXHi))
      field = fieldLabelM;
    else if (weekRow && inRange(pixelX, labelA1XLo, labelA1XHi))
      field = fieldLabelA1;
    else if (weekRow && inRange(pixelX, labelNXLo, labelNXHi))
      field = fieldLabelN;
    else if (weekRow && inRange(pixelX, labelA2XLo, labelA2XHi))
      field = fieldLabelA2;
    else if (weekRow && inRange(pixelX, weekUnitsXLo, weekUnitsXHi))
      field = fieldWeekUnits;
    else if (weekRow && inRange(pixelX, weekTensXLo, weekTensXHi))
      field = fieldWeekTens;
    // Calendar
    else if (dayRow && inRange(pixelX, dayTensXLo, dayTensXHi))
      field = fieldDayTens;
    else if (dayRow && inRange(pixelX, dayUnitsXLo, dayUnitsXHi))
      field = fieldDayUnits;
    else if (dateRow && inRange(pixelX, dateTensXLo, dateTensXHi))
      field = fieldDateTens;
    else if (dateRow && inRange(pixelX, dateUnitsXLo, dateUnitsXHi))
      field = fieldDateUnits;
    else if (yearRow && inRange(pixelX, yearZeroXLo, yearZeroXHi))
      field = fieldYearZero;  // Same columns as date tens, higher up
    else if (yearRow && inRange(pixelX, yearTwoXLo, yearTwoXHi))
      field = fieldYearTwo;
    else if (yearRow && inRange(pixelX, yearTensXLo, yearTensXHi))
      field = fieldYearTens;
    else if (yearRow && inRange(pixelX, yearUnitsXLo, yearUnitsXHi))
      field = fieldYearUnits;
    else if (monthRow && inRange(pixelX, monthTensXLo, monthTensXHi))
      field = fieldMonthTens;
    else if (monthRow && inRange(pixelX, monthUnitsXLo, monthUnitsXHi))
      field = fieldMonthUnits;
    else
      field = fieldNone;
  end

endmodule

/* source/glyphAddressReg.sv */
`timescale 1ns/1ps

module glyphAddressReg import clockOverlayPkg::*; (
  input  logic     clk,
  input  logic     rstN,
  input  coordT    pixelY,
  input  fieldT    field,
  input  charCodeT textChar,
  input  fontSizeT textFont,
  input  colorT    textColor,
  input  colorT    bandColor,
  output romAddrT  romAddr,
  output fontSizeT fontSize,
  output colorT    colorSel,
  output logic     glyphEnable
);

  logic       isText;
  charCodeT   nextChar;
  fontSizeT   nextFont;
  colorT      nextColor;
  logic [3:0] nextRow;

  assign isText = (field != fieldNone);

  // Text result or background result
  always_comb begin
    if (isText) begin
      nextChar  = textChar;
      nextFont  = textFont;
      nextColor = textColor;
    end else begin
      nextChar  = blankChar;
      nextFont  = fontNormal;
      nextColor = bandColor;
    end
    // Large glyphs repeat each ROM row over four screen lines
    nextRow = (nextFont == fontLarge) ? pixelY[5:2] : pixelY[3:0];
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      romAddr     <= '0;
      fontSize    <= fontNormal;
      colorSel    <= colorBackground;
      glyphEnable <= 1'b0;
    end else begin
      romAddr     <= {nextChar, nextRow};
      fontSize    <= nextFont;
      colorSel    <= nextColor;
      glyphEnable <= isText;  // Pixel comes from the glyph ROM
    end
  end

endmodule

/* testbench/clockOverlayTb.sv */
`timescale 1ns/1ps

module clockOverlayTb import clockOverlayPkg::*; ();

  localparam int ScreenLines  = 480;
  localparam int ResetCycles  = 8;
  localparam int ResetTimeout = 40;  // Cycles allowed for reset release
  localparam int DigitWords   = 16;
  localparam int VectorWords  = 6;   // x, y, romAddr, fontSize, colorSel, glyphEnable
  localparam int AddrBits     = 9;
  localparam int MemDepth     = 512;
  localparam int RandomCount  = 64;

  logic     clk;
  logic     rstN;
  coordT    pixelX;
  coordT    pixelY;
  charCodeT hourTens, hourUnits, minTens, minUnits;
  charCodeT secTens, secUnits, dateTens, dateUnits;
  charCodeT monthTens, monthUnits, yearTens, yearUnits;
  charCodeT dayTens, dayUnits, weekTens, weekUnits;
  romAddrT  romAddr;
  fontSizeT fontSize;
  colorT    colorSel;
  logic     glyphEnable;

  logic [11:0] stimMem [0:MemDepth-1];
  int          errorCount;
  int          checkCount;
  int          testCount;
  int          vectorCount;
  int          seed;

  clockOverlay #(.ScreenLines(ScreenLines)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1 rstN = 1'b1;
  end

  function automatic logic [11:0] wordAt(input int index);
    return stimMem[index[AddrBits-1:0]];
  endfunction

  // Words the file did not overwrite keep the out of range fill
  function automatic logic isLoaded(input int index);
    logic [11:0] w;
    w = wordAt(index);
    return w[11:10] == 2'b00;
  endfunction

  // Band colour for a row with no text, from the screen layout
  function automatic colorT expectedBand(input coordT y);
    if (y <= 10'd140) return colorBackground;
    if (y <= 10'd348) return colorBand;
    if (y <= 10'd351) return colorBackground;
    if (y <= 10'd353) return colorBand;
    if (y <= 10'd472) return colorBackground;
    if (y <= coordT'(ScreenLines)) return colorText;  // Footer bar
    return colorBackground;
  endfunction

  task automatic checkAddr(input romAddrT got, input romAddrT exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s romAddr is %03h, expected %03h", $time, what, got, exp);
    end
  endtask

  task automatic checkFont(input fontSizeT got, input fontSizeT exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s fontSize is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkColor(input colorT got, input colorT exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s colorSel is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkEnable(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s glyphEnable is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkAll(input romAddrT addr, input fontSizeT font, input colorT color,
                          input logic en, input string what);
    checkAddr(romAddr, addr, what);
    checkFont(fontSize, font, what);
    checkColor(colorSel, color, what);
    checkEnable(glyphEnable, en, what);
  endtask

  task automatic driveVector(input int v);
    logic [11:0] wx;
    logic [11:0] wy;
    wx = wordAt(DigitWords + v * VectorWords);
    wy = wordAt(DigitWords + v * VectorWords + 1);
    pixelX = wx[9:0];
    pixelY = wy[9:0];
  endtask

  task automatic checkVector(input int v, input string tag);
    int          base;
    logic [11:0] addrWord;
    logic [11:0] fontWord;
    logic [11:0] colorWord;
    logic [11:0] enWord;
    base      = DigitWords + v * VectorWords;
    addrWord  = wordAt(base + 2);
    fontWord  = wordAt(base + 3);
    colorWord = wordAt(base + 4);
    enWord    = wordAt(base + 5);
    checkAll(addrWord[10:0], fontSizeT'(fontWord[1:0]), colorT'(colorWord[2:0]), enWord[0],
             $sformatf("%s vector %0d", tag, v));
  endtask

  task automatic testLine(input string name, input int errs0, input int checks0);
    testCount++;
    $display("Test %-8s finished: %0d checks, %0d errors", name, checkCount - checks0,
             errorCount - errs0);
  endtask

  task automatic runResetCheck();
    int errs0;
    int checks0;
    errs0   = errorCount;
    checks0 = checkCount;
    checkAll(11'h000, fontNormal, colorBackground, 1'b0, "reset");
    testLine("reset", errs0, checks0);
  endtask

  // One vector at a time, result one edge later
  task automatic runSingleVectors();
    int errs0;
    int checks0;
    errs0   = errorCount;
    checks0 = checkCount;
    for (int v = 0; v < vectorCount; v++) begin
      @(posedge clk);
      #1 driveVector(v);
      @(posedge clk);
      #1 checkVector(v, "single");
    end
    testLine("single", errs0, checks0);
  endtask

  // New coordinate every cycle
  task automatic runStreamVectors();
    int errs0;
    int checks0;
    errs0   = errorCount;
    checks0 = checkCount;
    for (int v = 0; v <= vectorCount; v++) begin
      @(posedge clk);
      #1;
      if (v > 0)
        checkVector(v - 1, "stream");
      if (v < vectorCount)
        driveVector(v);
    end
    testLine("stream", errs0, checks0);
  endtask

  task automatic runRandomBackground();
    int      errs0;
    int      checks0;
    int      rnd;
    coordT   y;
    romAddrT expAddr;
    colorT   expColor;
    errs0   = errorCount;
    checks0 = checkCount;
    for (int i = 0; i <= RandomCount; i++) begin
      @(posedge clk);
      #1;
      if (i > 0)
        checkAll(expAddr, fontNormal, expColor, 1'b0, $sformatf("random y=%0d", y));
      if (i < RandomCount) begin
        rnd      = $random(seed);
        y        = rnd[17:8];
        pixelX   = {2'b00, rnd[7:0]};  // Left of every text field
        pixelY   = y;
        expAddr  = {blankChar, y[3:0]};
        expColor = expectedBand(y);
      end
    end
    testLine("random", errs0, checks0);
  endtask

  initial begin
    int waitCycles;
    pixelX      = 10'd298;  // Hour tens pixel so a missed reset shows
    pixelY      = 10'd245;
    errorCount  = 0;
    checkCount  = 0;
    testCount   = 0;
    vectorCount = 0;
    seed        = 9888;
    for (int i = 0; i < MemDepth; i++)
      stimMem[i] = {3'b111, i[8:0]};  // Out of range coordinate in every unloaded word
    $readmemh("testbench/overlayStimulus.mem", stimMem);
    hourTens   = stimMem[0][6:0];
    hourUnits  = stimMem[1][6:0];
    minTens    = stimMem[2][6:0];
    minUnits   = stimMem[3][6:0];
    secTens    = stimMem[4][6:0];
    secUnits   = stimMem[5][6:0];
    dateTens   = stimMem[6][6:0];
    dateUnits  = stimMem[7][6:0];
    monthTens  = stimMem[8][6:0];
    monthUnits = stimMem[9][6:0];
    yearTens   = stimMem[10][6:0];
    yearUnits  = stimMem[11][6:0];
    dayTens    = stimMem[12][6:0];
    dayUnits   = stimMem[13][6:0];
    weekTens   = stimMem[14][6:0];
    weekUnits  = stimMem[15][6:0];
    // Vectors end at the first unloaded word
    while (DigitWords + (vectorCount + 1) * VectorWords <= MemDepth &&
           isLoaded(DigitWords + vectorCount * VectorWords))
      vectorCount++;
    if (vectorCount == 0) begin
      errorCount++;
      $display("The stimulus file holds no test vectors");
    end
    waitCycles = 0;
    while (rstN !== 1'b1 && waitCycles < ResetTimeout) begin
      @(negedge clk);
      waitCycles++;
    end
    if (rstN !== 1'b1) begin
      errorCount++;
      $display("Timeout: reset still asserted after %0d cycles", waitCycles);
    end else begin
      runResetCheck();
      runSingleVectors();
      runStreamVectors();
      runRandomBackground();
    end
    errorCount += UUT.uAssert.failCount;
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* testbench/clockOverlay_assert.sv */
`timescale 1ns/1ps

module clockOverlayAssert import clockOverlayPkg::*; (
  input logic  clk,
  input logic  rstN,
  input colorT colorSel,
  input logic  glyphEnable
);

  int failCount = 0;  // Number of failed assertions

  // Glyph pixels always use the text palette entry
  assert property (@(posedge clk) disable iff (!rstN) glyphEnable |-> colorSel == colorText)
    else begin
      $error("glyphEnable high while colorSel is %0d", colorSel);
      failCount++;
    end

  // Register cleared by a reset edge
  assert property (@(posedge clk) !rstN |=> !glyphEnable)
    else begin
      $error("glyphEnable high in the cycle after reset");
      failCount++;
    end

endmodule

bind clockOverlay clockOverlayAssert uAssert (
  .clk         (clk),
  .rstN        (rstN),
  .colorSel    (colorSel),
  .glyphEnable (glyphEnable)
);

/* testbench/overlayStimulus.mem */
// Line 1: hourTens hourUnits minTens minUnits secTens secUnits dateTens dateUnits
//         monthTens monthUnits yearTens yearUnits dayTens dayUnits weekTens weekUnits
// Then: pixelX pixelY romAddr fontSize colorSel glyphEnable
31 32 33 34 35 36 37 38 39 30 61 62 63 64 65 66
12A 0F5 315 1 2 1 // hour tens
136 0FF 32F 1 2 1 // hour units, last row
13F 0F0 330 1 2 1 // min tens
14E 0FA 34A 1 2 1 // min units
15F 101 351 1 2 1 // sec tens, bottom line
160 0F2 362 1 2 1 // sec units
159 0F1 0A1 1 1 0 // just above seconds
11F 010 530 1 2 1 // S
12C 014 454 1 2 1 // E
131 01D 4DD 1 2 1 // M
13F 012 412 1 2 1 // A
140 016 4E6 1 2 1 // N
14E 019 419 1 2 1 // A
157 011 651 1 2 1 // week tens
166 01C 66C 1 2 1 // week units
247 1A2 322 1 2 1 // year prefix 2
24F 1AC 30B 2 2 1 // year prefix 0, large
257 1A7 617 1 2 1 // year tens
266 1A2 622 1 2 1 // year units
24F 1B2 372 1 2 1 // date tens under the large 0
25E 1BE 38E 1 2 1 // date units
23F 1C2 632 1 2 1 // weekday tens
24E 1CD 64D 1 2 1 // weekday units
25F 1C7 397 1 2 1 // month tens under year units
26E 1CC 30C 1 2 1 // month units
064 08C 0AC 1 0 0 // y 140
064 08D 0AD 1 1 0 // y 141
064 15C 0AC 1 1 0 // y 348
064 15D 0AD 1 0 0 // y 349
064 160 0A0 1 1 0 // y 352
064 1D8 0A8 1 0 0 // y 472
064 1D9 0A9 1 2 0 // y 473
064 1E0 0A0 1 2 0 // y 480
064 1E1 0A1 1 0 0 // y 481
